//--- tapasco_dm_top.f
dm_wrap_pkg.sv
dm_csrs.sv
dm_debug_mem.sv
axi_mem_bridge.sv
tapasco_dm_top.sv
tb_tapasco_dm_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tapasco_dm_top
FILELIST  ?= tapasco_dm_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "Simulation result: FAIL"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "Simulation result: no pass line"; exit 1; fi
	@echo "Simulation result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_tapasco_dm_top.sv
`timescale 1ns/1ps

module tb_tapasco_dm_top;

    localparam int          CLK_HALF        = 50;
    localparam int          RST_CYCLES      = 8;
    localparam int          CYCLES_PER_STEP = 20;
    localparam logic [31:0] SEED            = 32'h97209d20;
    localparam logic [63:0] DM_BASE         = 64'h0000_0000_0001_0000; // Only bits 11:0 decode

    typedef enum logic [2:0] {
        DMI_WR,
        DMI_RD,
        AXI_WR,
        AXI_RD,
        LEVEL
    } step_kind_e;

    typedef struct {
        string                              name;
        step_kind_e                         kind;
        logic [dm_wrap_pkg::AXI_ADDR_W-1:0] addr;
        logic [dm_wrap_pkg::AXI_DATA_W-1:0] data;
        logic [dm_wrap_pkg::AXI_STRB_W-1:0] strb;
        logic [dm_wrap_pkg::AXI_DATA_W-1:0] exp;
        logic [1:0]                         resp;
        logic [dm_wrap_pkg::AXI_ID_W-1:0]   id;
    } step_t;

    logic                               clk;
    logic                               rst_n;
    logic                               debug_req;
    logic                               dmi_req;
    logic                               dmi_wr;
    logic [dm_wrap_pkg::DMI_ADDR_W-1:0] dmi_addr;
    logic [dm_wrap_pkg::DMI_DATA_W-1:0] dmi_wdata;
    logic [dm_wrap_pkg::DMI_DATA_W-1:0] dmi_rdata;
    dm_wrap_pkg::axi_req_t              axi_req;
    dm_wrap_pkg::axi_resp_t             axi_resp;
    step_t                              steps[$];
    logic                               table_built = 1'b0;

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    tapasco_dm_top u_tapasco_dm_top (
        .clk_i            ( clk       ),
        .rst_n_i          ( rst_n     ),
        .debug_req_core_o ( debug_req ),
        .dmi_req_i        ( dmi_req   ),
        .dmi_wr_i         ( dmi_wr    ),
        .dmi_addr_i       ( dmi_addr  ),
        .dmi_wdata_i      ( dmi_wdata ),
        .dmi_rdata_o      ( dmi_rdata ),
        .axi_req_i        ( axi_req   ),
        .axi_resp_o       ( axi_resp  )
    );

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_dmi_data(input string name,
                                  input logic [dm_wrap_pkg::DMI_DATA_W-1:0] exp,
                                  input logic [dm_wrap_pkg::DMI_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_axi_data(input string name,
                                  input logic [dm_wrap_pkg::AXI_DATA_W-1:0] exp,
                                  input logic [dm_wrap_pkg::AXI_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected resp %b, actual resp %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_id(input string name,
                            input logic [dm_wrap_pkg::AXI_ID_W-1:0] exp,
                            input logic [dm_wrap_pkg::AXI_ID_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected id %h, actual id %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_user(input string name,
                              input logic [dm_wrap_pkg::AXI_USER_W-1:0] exp,
                              input logic [dm_wrap_pkg::AXI_USER_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected user %h, actual user %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // Level strobe, one cycle per access
    task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
        dmi_req   = 1'b1;
        dmi_wr    = 1'b1;
        dmi_addr  = addr;
        dmi_wdata = data;
        @(negedge clk);
        dmi_req = 1'b0;
        dmi_wr  = 1'b0;
    endtask

    task automatic dmi_read(input logic [6:0] addr, output logic [31:0] data);
        dmi_req  = 1'b1;
        dmi_wr   = 1'b0;
        dmi_addr = addr;
        @(negedge clk);
        dmi_req = 1'b0;
        data    = dmi_rdata; // Registered at the edge just passed
    endtask

    task automatic axi_write(input logic [63:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, input logic [4:0] id,
                             output logic [1:0] resp, output logic [4:0] bid,
                             output logic [dm_wrap_pkg::AXI_USER_W-1:0] buser);
        axi_req.aw.id    = id;
        axi_req.aw.addr  = addr;
        axi_req.aw.len   = 8'd0;
        axi_req.aw.size  = 3'd3;
        axi_req.aw.burst = 2'b01;
        axi_req.aw_valid = 1'b1;
        do begin
            @(negedge clk);
        end while (!axi_resp.w_ready);
        axi_req.aw_valid = 1'b0;
        axi_req.w.data   = data;
        axi_req.w.strb   = strb;
        axi_req.w.last   = 1'b1;
        axi_req.w_valid  = 1'b1;
        do begin
            @(negedge clk);
        end while (!axi_resp.b_valid);
        axi_req.w_valid = 1'b0;
        resp            = axi_resp.b.resp;
        bid             = axi_resp.b.id;
        buser           = axi_resp.b.user;
        axi_req.b_ready = 1'b1;
        @(negedge clk);
        axi_req.b_ready = 1'b0;
    endtask

    task automatic axi_read(input logic [63:0] addr, input logic [4:0] id,
                            output logic [63:0] data, output logic [1:0] resp,
                            output logic [4:0] rid, output logic rlast,
                            output logic [dm_wrap_pkg::AXI_USER_W-1:0] ruser);
        axi_req.ar.id    = id;
        axi_req.ar.addr  = addr;
        axi_req.ar.len   = 8'd0;
        axi_req.ar.size  = 3'd3;
        axi_req.ar.burst = 2'b01;
        axi_req.ar_valid = 1'b1;
        do begin
            @(negedge clk);
        end while (!axi_resp.r_valid);
        axi_req.ar_valid = 1'b0;
        data             = axi_resp.r.data;
        resp             = axi_resp.r.resp;
        rid              = axi_resp.r.id;
        rlast            = axi_resp.r.last;
        ruser            = axi_resp.r.user;
        axi_req.r_ready  = 1'b1;
        @(negedge clk);
        axi_req.r_ready = 1'b0;
    endtask

    function automatic logic [63:0] dmstatus_for(input logic halted);
        logic [31:0] v;
        v = 32'd0;
        v[3:0]  = 4'd2;
        v[dm_wrap_pkg::DMSTATUS_AUTH_BIT]       = 1'b1;
        v[dm_wrap_pkg::DMSTATUS_ANYHALTED_BIT]  = halted;
        v[dm_wrap_pkg::DMSTATUS_ALLHALTED_BIT]  = halted;
        v[dm_wrap_pkg::DMSTATUS_ANYRUNNING_BIT] = ~halted;
        v[dm_wrap_pkg::DMSTATUS_ALLRUNNING_BIT] = ~halted;
        return {32'd0, v};
    endfunction

    function automatic logic [63:0] apply_strobe(input logic [63:0] old,
                                                 input logic [63:0] wdata,
                                                 input logic [7:0]  strb);
        logic [63:0] v;
        v = old;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) v[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return v;
    endfunction

    function automatic void table_entry(input string name, input step_kind_e kind,
                                        input logic [63:0] addr, input logic [63:0] data,
                                        input logic [7:0] strb, input logic [63:0] exp,
                                        input logic [1:0] resp);
        step_t       s;
        logic [31:0] rnd;
        rnd    = $urandom();
        s.name = name;
        s.kind = kind;
        s.addr = addr;
        s.data = data;
        s.strb = strb;
        s.exp  = exp;
        s.resp = resp;
        s.id   = rnd[4:0];
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        logic [63:0] a_data0;
        logic [63:0] a_data1;
        logic [63:0] a_ctrl;
        logic [63:0] a_stat;
        logic [63:0] m_data;
        logic [63:0] m_halt;
        logic [63:0] m_resume;
        logic [63:0] word;
        logic [63:0] wdata;
        logic [1:0]  ok;
        logic [1:0]  dec;
        a_data0  = 64'(dm_wrap_pkg::DMI_DATA0);
        a_data1  = 64'(dm_wrap_pkg::DMI_DATA1);
        a_ctrl   = 64'(dm_wrap_pkg::DMI_DMCONTROL);
        a_stat   = 64'(dm_wrap_pkg::DMI_DMSTATUS);
        m_data   = DM_BASE | 64'(dm_wrap_pkg::MEM_DATA);
        m_halt   = DM_BASE | 64'(dm_wrap_pkg::MEM_HALTED);
        m_resume = DM_BASE | 64'(dm_wrap_pkg::MEM_RESUMING);
        ok       = dm_wrap_pkg::RESP_OKAY;
        dec      = dm_wrap_pkg::RESP_DECERR;
        word     = {$urandom(), $urandom()};
        wdata    = {$urandom(), $urandom()};

        table_entry("reset_dmstatus", DMI_RD, a_stat, 64'd0, 8'h00, dmstatus_for(1'b0), ok);
        table_entry("reset_debug_req", LEVEL, 64'd0, 64'd0, 8'h00, 64'd0, ok);
        table_entry("wr_data0", DMI_WR, a_data0, {32'd0, word[31:0]}, 8'h00, 64'd0, ok);
        table_entry("wr_data1", DMI_WR, a_data1, {32'd0, word[63:32]}, 8'h00, 64'd0, ok);
        table_entry("rd_data0", DMI_RD, a_data0, 64'd0, 8'h00, {32'd0, word[31:0]}, ok);
        table_entry("rd_data1", DMI_RD, a_data1, 64'd0, 8'h00, {32'd0, word[63:32]}, ok);
        table_entry("axi_rd_word", AXI_RD, m_data, 64'd0, 8'h00, word, ok);

        // Partial strobes, first across both halves, then data0 only
        table_entry("axi_wr_strb96", AXI_WR, m_data, wdata, 8'h96, 64'd0, ok);
        word = apply_strobe(word, wdata, 8'h96);
        table_entry("strb96_data0", DMI_RD, a_data0, 64'd0, 8'h00, {32'd0, word[31:0]}, ok);
        table_entry("strb96_data1", DMI_RD, a_data1, 64'd0, 8'h00, {32'd0, word[63:32]}, ok);
        wdata = {$urandom(), $urandom()};
        table_entry("axi_wr_strb0c", AXI_WR, m_data, wdata, 8'h0c, 64'd0, ok);
        word = apply_strobe(word, wdata, 8'h0c);
        table_entry("strb0c_data0", DMI_RD, a_data0, 64'd0, 8'h00, {32'd0, word[31:0]}, ok);
        table_entry("strb0c_data1", DMI_RD, a_data1, 64'd0, 8'h00, {32'd0, word[63:32]}, ok);

        // haltreq in bit 31, dmactive in bit 0
        table_entry("wr_ctrl_halt", DMI_WR, a_ctrl, 64'h8000_0001, 8'h00, 64'd0, ok);
        table_entry("halt_debug_req", LEVEL, 64'd0, 64'd0, 8'h00, 64'd1, ok);
        table_entry("rd_ctrl_halt", DMI_RD, a_ctrl, 64'd0, 8'h00, 64'h8000_0001, ok);
        table_entry("wr_ctrl_inactive", DMI_WR, a_ctrl, 64'h8000_0000, 8'h00, 64'd0, ok);
        table_entry("inactive_debug_req", LEVEL, 64'd0, 64'd0, 8'h00, 64'd0, ok);
        table_entry("rd_ctrl_inactive", DMI_RD, a_ctrl, 64'd0, 8'h00, 64'd0, ok);

        table_entry("axi_wr_halted", AXI_WR, m_halt, 64'd0, 8'hff, 64'd0, ok);
        table_entry("dmstatus_halted", DMI_RD, a_stat, 64'd0, 8'h00, dmstatus_for(1'b1), ok);
        table_entry("axi_rd_halted_1", AXI_RD, m_halt, 64'd0, 8'h00, 64'd1, ok);
        table_entry("axi_wr_resuming", AXI_WR, m_resume, 64'd0, 8'hff, 64'd0, ok);
        table_entry("dmstatus_running", DMI_RD, a_stat, 64'd0, 8'h00, dmstatus_for(1'b0), ok);
        table_entry("axi_rd_halted_0", AXI_RD, m_halt, 64'd0, 8'h00, 64'd0, ok);

        // Unmapped offsets must not disturb any state
        table_entry("axi_wr_unmapped", AXI_WR, DM_BASE | 64'h200, ~word, 8'hff, 64'd0, dec);
        table_entry("axi_rd_unmapped", AXI_RD, DM_BASE | 64'h384, 64'd0, 8'h00, 64'd0, dec);
        table_entry("after_dec_data0", DMI_RD, a_data0, 64'd0, 8'h00, {32'd0, word[31:0]}, ok);
        table_entry("after_dec_data1", DMI_RD, a_data1, 64'd0, 8'h00, {32'd0, word[63:32]}, ok);
        table_entry("after_dec_status", DMI_RD, a_stat, 64'd0, 8'h00, dmstatus_for(1'b0), ok);
        table_entry("after_dec_word", AXI_RD, m_data, 64'd0, 8'h00, word, ok);
        table_entry("dmi_rd_unmapped", DMI_RD, 64'h20, 64'd0, 8'h00, 64'd0, ok);
    endfunction

    initial begin
        logic [dm_wrap_pkg::DMI_DATA_W-1:0] rd32;
        logic [dm_wrap_pkg::AXI_DATA_W-1:0] rd64;
        logic [1:0]                         rsp;
        logic [dm_wrap_pkg::AXI_ID_W-1:0]   rid;
        logic                               rlast;
        logic [dm_wrap_pkg::AXI_USER_W-1:0] usr;

        rst_n     = 1'b0;
        dmi_req   = 1'b0;
        dmi_wr    = 1'b0;
        dmi_addr  = '0;
        dmi_wdata = '0;
        axi_req   = '0;
        void'($urandom(SEED));
        build_table();
        table_built = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        foreach (steps[i]) begin
            case (steps[i].kind)
                DMI_WR: dmi_write(steps[i].addr[6:0], steps[i].data[31:0]);
                DMI_RD: begin
                    dmi_read(steps[i].addr[6:0], rd32);
                    check_dmi_data(steps[i].name, steps[i].exp[31:0], rd32);
                end
                AXI_WR: begin
                    axi_write(steps[i].addr, steps[i].data, steps[i].strb, steps[i].id,
                              rsp, rid, usr);
                    check_resp(steps[i].name, steps[i].resp, rsp);
                    check_id(steps[i].name, steps[i].id, rid);
                    check_user({steps[i].name, " buser"}, '0, usr);
                end
                AXI_RD: begin
                    axi_read(steps[i].addr, steps[i].id, rd64, rsp, rid, rlast, usr);
                    check_resp(steps[i].name, steps[i].resp, rsp);
                    check_id(steps[i].name, steps[i].id, rid);
                    check_level({steps[i].name, " rlast"}, 1'b1, rlast);
                    check_user({steps[i].name, " ruser"}, '0, usr);
                    if (steps[i].resp == dm_wrap_pkg::RESP_OKAY) begin
                        check_axi_data(steps[i].name, steps[i].exp, rd64);
                    end
                end
                default: begin
                    check_level(steps[i].name, steps[i].exp[0], debug_req);
                    // Bridge sits idle between transactions
                    check_level({steps[i].name, " aw_ready"}, 1'b1, axi_resp.aw_ready);
                    check_level({steps[i].name, " ar_ready"}, 1'b1, axi_resp.ar_ready);
                    check_level({steps[i].name, " r_valid"}, 1'b0, axi_resp.r_valid);
                    check_level({steps[i].name, " b_valid"}, 1'b0, axi_resp.b_valid);
                end
            endcase
        end

        $display("Everything OK");
        $finish;
    end

    // Watchdog scaled to the table
    initial begin
        wait (table_built);
        repeat (RST_CYCLES + steps.size() * CYCLES_PER_STEP) @(posedge clk);
        $display("Timeout: the %0d test steps did not complete in time", steps.size());
        abort_run();
    end

endmodule

//--- tapasco_dm_top.sv
`timescale 1ns/1ps

module tapasco_dm_top (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    output logic                               debug_req_core_o,
    // DMI pins, level strobe
    input  logic                               dmi_req_i,
    input  logic                               dmi_wr_i,
    input  logic [dm_wrap_pkg::DMI_ADDR_W-1:0] dmi_addr_i,
    input  logic [dm_wrap_pkg::DMI_DATA_W-1:0] dmi_wdata_i,
    output logic [dm_wrap_pkg::DMI_DATA_W-1:0] dmi_rdata_o,
    // Core-side AXI slave
    input  dm_wrap_pkg::axi_req_t              axi_req_i,
    output dm_wrap_pkg::axi_resp_t             axi_resp_o
);

    dm_wrap_pkg::dmi_req_t              dmi_req;
    dm_wrap_pkg::mem_req_t              mem_req;
    dm_wrap_pkg::mem_rsp_t              mem_rsp;
    dm_wrap_pkg::data_wr_t              core_wr;
    logic                               halted;
    logic [dm_wrap_pkg::DMI_DATA_W-1:0] data0;
    logic [dm_wrap_pkg::DMI_DATA_W-1:0] data1;

    assign dmi_req.wr   = dmi_wr_i;
    assign dmi_req.addr = dmi_addr_i;
    assign dmi_req.data = dmi_wdata_i;

    dm_csrs u_csrs (
        .clk_i       ( clk_i            ),
        .rst_n_i     ( rst_n_i          ),
        .dmi_valid_i ( dmi_req_i        ), // Every high cycle is an access
        .dmi_req_i   ( dmi_req          ),
        .core_wr_i   ( core_wr          ),
        .halted_i    ( halted           ),
        .dmi_rdata_o ( dmi_rdata_o      ),
        .data0_o     ( data0            ),
        .data1_o     ( data1            ),
        .debug_req_o ( debug_req_core_o )
    );

    dm_debug_mem u_debug_mem (
        .clk_i     ( clk_i   ),
        .rst_n_i   ( rst_n_i ),
        .mem_req_i ( mem_req ),
        .data0_i   ( data0   ),
        .data1_i   ( data1   ),
        .mem_rsp_o ( mem_rsp ),
        .data_wr_o ( core_wr ),
        .halted_o  ( halted  )
    );

    axi_mem_bridge u_axi_bridge (
        .clk_i      ( clk_i      ),
        .rst_n_i    ( rst_n_i    ),
        .axi_req_i  ( axi_req_i  ),
        .mem_rsp_i  ( mem_rsp    ),
        .axi_resp_o ( axi_resp_o ),
        .mem_req_o  ( mem_req    )
    );

endmodule

//--- axi_mem_bridge.sv
`timescale 1ns/1ps

module axi_mem_bridge (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  dm_wrap_pkg::axi_req_t  axi_req_i,
    input  dm_wrap_pkg::mem_rsp_t  mem_rsp_i,
    output dm_wrap_pkg::axi_resp_t axi_resp_o,
    output dm_wrap_pkg::mem_req_t  mem_req_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_W,
        ST_READ_RSP,
        ST_WRITE_RSP
    } state_e;

    state_e                               state_q;
    state_e                               state_d;
    logic [dm_wrap_pkg::AXI_ID_W-1:0]     id_q;
    logic [dm_wrap_pkg::AXI_ADDR_W-1:0]   addr_q;
    logic [dm_wrap_pkg::AXI_DATA_W-1:0]   rdata_q;
    logic [1:0]                           resp_q;
    logic                                 ar_hs;
    logic                                 aw_hs;
    logic                                 w_hs;
    logic [1:0]                           mem_resp;

    // Reads win over writes in idle
    assign ar_hs = (state_q == ST_IDLE) & axi_req_i.ar_valid;
    assign aw_hs = (state_q == ST_IDLE) & axi_req_i.aw_valid & ~axi_req_i.ar_valid;
    assign w_hs  = (state_q == ST_WAIT_W) & axi_req_i.w_valid;

    assign mem_resp = mem_rsp_i.err ? dm_wrap_pkg::RESP_DECERR : dm_wrap_pkg::RESP_OKAY;

    // One memory access per transaction
    assign mem_req_o.req   = ar_hs | w_hs;
    assign mem_req_o.we    = state_q == ST_WAIT_W;
    assign mem_req_o.addr  = (state_q == ST_WAIT_W) ? addr_q : axi_req_i.ar.addr;
    assign mem_req_o.be    = axi_req_i.w.strb;
    assign mem_req_o.wdata = axi_req_i.w.data;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (ar_hs) begin
                    state_d = ST_READ_RSP;
                end else if (aw_hs) begin
                    state_d = ST_WAIT_W;
                end
            end
            ST_WAIT_W: begin
                if (w_hs) state_d = ST_WRITE_RSP;
            end
            ST_READ_RSP: begin
                if (axi_req_i.r_ready) state_d = ST_IDLE;
            end
            ST_WRITE_RSP: begin
                if (axi_req_i.b_ready) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            id_q    <= axi_req_i.ar.id;
            rdata_q <= mem_rsp_i.rdata; // Memory answers in the same cycle
            resp_q  <= mem_resp;
        end else if (aw_hs) begin
            id_q   <= axi_req_i.aw.id;
            addr_q <= axi_req_i.aw.addr;
        end else if (w_hs) begin
            resp_q <= mem_resp;
        end
    end

    assign axi_resp_o.aw_ready = aw_hs | ((state_q == ST_IDLE) & ~axi_req_i.ar_valid);
    assign axi_resp_o.ar_ready = state_q == ST_IDLE;
    assign axi_resp_o.w_ready  = state_q == ST_WAIT_W;

    assign axi_resp_o.b_valid = state_q == ST_WRITE_RSP;
    assign axi_resp_o.b.id    = id_q;
    assign axi_resp_o.b.resp  = resp_q;
    assign axi_resp_o.b.user  = '0;

    assign axi_resp_o.r_valid = state_q == ST_READ_RSP;
    assign axi_resp_o.r.id    = id_q;
    assign axi_resp_o.r.data  = rdata_q;
    assign axi_resp_o.r.resp  = resp_q;
    assign axi_resp_o.r.last  = 1'b1; // Single beat only
    assign axi_resp_o.r.user  = '0;

    // Bursts are not supported on this port
    a_awlen_zero: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        axi_req_i.aw_valid |-> axi_req_i.aw.len == 8'd0
    );

    a_arlen_zero: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        axi_req_i.ar_valid |-> axi_req_i.ar.len == 8'd0
    );

endmodule

//--- dm_debug_mem.sv
`timescale 1ns/1ps

module dm_debug_mem (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  dm_wrap_pkg::mem_req_t              mem_req_i,
    input  logic [dm_wrap_pkg::DMI_DATA_W-1:0] data0_i,
    input  logic [dm_wrap_pkg::DMI_DATA_W-1:0] data1_i,
    output dm_wrap_pkg::mem_rsp_t              mem_rsp_o,
    output dm_wrap_pkg::data_wr_t              data_wr_o,
    output logic                               halted_o
);

    logic                                  halted_q;
    logic [dm_wrap_pkg::MEM_OFFS_W-1:0]    offs;
    logic                                  hit_halted;
    logic                                  hit_resuming;
    logic                                  hit_data;
    logic                                  wr_en;
    logic [dm_wrap_pkg::AXI_DATA_W-1:0]    cur_word;
    logic [dm_wrap_pkg::AXI_DATA_W-1:0]    merged;

    assign offs         = mem_req_i.addr[dm_wrap_pkg::MEM_OFFS_W-1:0];
    assign hit_halted   = offs == dm_wrap_pkg::MEM_HALTED;
    assign hit_resuming = offs == dm_wrap_pkg::MEM_RESUMING;
    assign hit_data     = offs == dm_wrap_pkg::MEM_DATA;
    assign wr_en        = mem_req_i.req & mem_req_i.we;

    assign cur_word = {data1_i, data0_i};

    always_comb begin
        for (int i = 0; i < dm_wrap_pkg::AXI_STRB_W; i++) begin
            merged[i*8 +: 8] = mem_req_i.be[i] ? mem_req_i.wdata[i*8 +: 8] : cur_word[i*8 +: 8];
        end
    end

    // Lanes 3:0 belong to data0
    assign data_wr_o.wr0  = wr_en & hit_data & (|mem_req_i.be[3:0]);
    assign data_wr_o.wr1  = wr_en & hit_data & (|mem_req_i.be[7:4]);
    assign data_wr_o.data = merged;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            halted_q <= 1'b0;
        end else if (wr_en && hit_halted) begin
            halted_q <= 1'b1;
        end else if (wr_en && hit_resuming) begin
            halted_q <= 1'b0;
        end
    end

    always_comb begin
        mem_rsp_o.rdata = '0;
        if (hit_halted) begin
            mem_rsp_o.rdata[0] = halted_q;
        end else if (hit_data) begin
            mem_rsp_o.rdata = cur_word;
        end
        mem_rsp_o.err = ~(hit_halted | hit_resuming | hit_data);
    end

    assign halted_o = halted_q;

endmodule

//--- dm_csrs.sv
`timescale 1ns/1ps

module dm_csrs (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   dmi_valid_i,
    input  dm_wrap_pkg::dmi_req_t                  dmi_req_i,
    input  dm_wrap_pkg::data_wr_t                  core_wr_i,
    input  logic                                   halted_i,
    output logic [dm_wrap_pkg::DMI_DATA_W-1:0]     dmi_rdata_o,
    output logic [dm_wrap_pkg::DMI_DATA_W-1:0]     data0_o,
    output logic [dm_wrap_pkg::DMI_DATA_W-1:0]     data1_o,
    output logic                                   debug_req_o
);

    logic [dm_wrap_pkg::DMI_DATA_W-1:0] data0_q;
    logic [dm_wrap_pkg::DMI_DATA_W-1:0] data1_q;
    logic                               dmactive_q;
    logic                               haltreq_q;
    logic [dm_wrap_pkg::DMI_DATA_W-1:0] rdata_q;
    logic [dm_wrap_pkg::DMI_DATA_W-1:0] rdata_d;
    logic                               dmi_wr;
    logic                               dmi_rd;

    assign dmi_wr = dmi_valid_i & dmi_req_i.wr;
    assign dmi_rd = dmi_valid_i & ~dmi_req_i.wr;

    always_comb begin
        logic [dm_wrap_pkg::DMI_DATA_W-1:0] dmstatus;
        logic [dm_wrap_pkg::DMI_DATA_W-1:0] dmcontrol;

        dmstatus = '0;
        dmstatus[3:0] = dm_wrap_pkg::DMSTATUS_VERSION;
        dmstatus[dm_wrap_pkg::DMSTATUS_AUTH_BIT]       = 1'b1; // No authentication
        dmstatus[dm_wrap_pkg::DMSTATUS_ANYHALTED_BIT]  = halted_i;
        dmstatus[dm_wrap_pkg::DMSTATUS_ALLHALTED_BIT]  = halted_i;
        dmstatus[dm_wrap_pkg::DMSTATUS_ANYRUNNING_BIT] = ~halted_i;
        dmstatus[dm_wrap_pkg::DMSTATUS_ALLRUNNING_BIT] = ~halted_i;

        dmcontrol = '0;
        dmcontrol[dm_wrap_pkg::DMCTRL_DMACTIVE_BIT] = dmactive_q;
        dmcontrol[dm_wrap_pkg::DMCTRL_HALTREQ_BIT]  = haltreq_q;

        case (dmi_req_i.addr)
            dm_wrap_pkg::DMI_DATA0:     rdata_d = data0_q;
            dm_wrap_pkg::DMI_DATA1:     rdata_d = data1_q;
            dm_wrap_pkg::DMI_DMCONTROL: rdata_d = dmcontrol;
            dm_wrap_pkg::DMI_DMSTATUS:  rdata_d = dmstatus;
            default:                    rdata_d = '0; // Unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data0_q    <= '0;
            data1_q    <= '0;
            dmactive_q <= 1'b0;
            haltreq_q  <= 1'b0;
            rdata_q    <= '0;
        end else begin
            // DMI has priority over the core side
            if (dmi_wr && dmi_req_i.addr == dm_wrap_pkg::DMI_DATA0) begin
                data0_q <= dmi_req_i.data;
            end else if (core_wr_i.wr0) begin
                data0_q <= core_wr_i.data[31:0];
            end

            if (dmi_wr && dmi_req_i.addr == dm_wrap_pkg::DMI_DATA1) begin
                data1_q <= dmi_req_i.data;
            end else if (core_wr_i.wr1) begin
                data1_q <= core_wr_i.data[63:32];
            end

            if (dmi_wr && dmi_req_i.addr == dm_wrap_pkg::DMI_DMCONTROL) begin
                dmactive_q <= dmi_req_i.data[dm_wrap_pkg::DMCTRL_DMACTIVE_BIT];
                // Haltreq only survives with an active session
                haltreq_q  <= dmi_req_i.data[dm_wrap_pkg::DMCTRL_HALTREQ_BIT] &
                              dmi_req_i.data[dm_wrap_pkg::DMCTRL_DMACTIVE_BIT];
            end

            if (dmi_rd) begin
                rdata_q <= rdata_d; // Held until the next read
            end
        end
    end

    assign dmi_rdata_o = rdata_q;
    assign data0_o     = data0_q;
    assign data1_o     = data1_q;
    assign debug_req_o = haltreq_q;

    // Every strobed DMI access must carry a known address from the pins
    a_dmi_addr_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        dmi_valid_i |-> !$isunknown(dmi_req_i.addr)
    );

endmodule

//--- dm_wrap_pkg.sv
package dm_wrap_pkg;

    // Bus widths
    localparam int unsigned DMI_ADDR_W = 7;
    localparam int unsigned DMI_DATA_W = 32;
    localparam int unsigned AXI_ADDR_W = 64;
    localparam int unsigned AXI_DATA_W = 64;
    localparam int unsigned AXI_STRB_W = 8;
    localparam int unsigned AXI_ID_W   = 5;
    localparam int unsigned AXI_USER_W = 4;

    // DMI register map
    localparam logic [DMI_ADDR_W-1:0] DMI_DATA0     = 7'h04;
    localparam logic [DMI_ADDR_W-1:0] DMI_DATA1     = 7'h05;
    localparam logic [DMI_ADDR_W-1:0] DMI_DMCONTROL = 7'h10;
    localparam logic [DMI_ADDR_W-1:0] DMI_DMSTATUS  = 7'h11;

    localparam int unsigned DMCTRL_DMACTIVE_BIT     = 0;
    localparam int unsigned DMCTRL_HALTREQ_BIT      = 31;
    localparam logic [3:0]  DMSTATUS_VERSION        = 4'd2; // Debug spec 0.13
    localparam int unsigned DMSTATUS_AUTH_BIT       = 7;
    localparam int unsigned DMSTATUS_ANYHALTED_BIT  = 8;
    localparam int unsigned DMSTATUS_ALLHALTED_BIT  = 9;
    localparam int unsigned DMSTATUS_ANYRUNNING_BIT = 10;
    localparam int unsigned DMSTATUS_ALLRUNNING_BIT = 11;

    // Core-side debug memory, offsets within the 4 KiB window
    localparam int unsigned      MEM_OFFS_W   = 12;
    localparam logic [MEM_OFFS_W-1:0] MEM_HALTED   = 12'h100;
    localparam logic [MEM_OFFS_W-1:0] MEM_RESUMING = 12'h108;
    localparam logic [MEM_OFFS_W-1:0] MEM_DATA     = 12'h380;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    typedef struct packed {
        logic                  wr;
        logic [DMI_ADDR_W-1:0] addr;
        logic [DMI_DATA_W-1:0] data;
    } dmi_req_t;

    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_STRB_W-1:0] be;
        logic [AXI_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] rdata;
        logic                  err;
    } mem_rsp_t;

    typedef struct packed {
        logic                  wr0;
        logic                  wr1;
        logic [AXI_DATA_W-1:0] data; // data1 in the upper half
    } data_wr_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic                  lock;
        logic [3:0]            cache;
        logic [2:0]            prot;
        logic [3:0]            qos;
        logic [3:0]            region;
        logic [5:0]            atop;
        logic [AXI_USER_W-1:0] user;
    } axi_aw_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic                  lock;
        logic [3:0]            cache;
        logic [2:0]            prot;
        logic [3:0]            qos;
        logic [3:0]            region;
        logic [AXI_USER_W-1:0] user;
    } axi_ar_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
        logic [AXI_USER_W-1:0] user;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [1:0]            resp;
        logic [AXI_USER_W-1:0] user;
    } axi_b_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        logic                  last;
        logic [AXI_USER_W-1:0] user;
    } axi_r_t;

    typedef struct packed {
        axi_aw_t aw;
        logic    aw_valid;
        axi_w_t  w;
        logic    w_valid;
        logic    b_ready;
        axi_ar_t ar;
        logic    ar_valid;
        logic    r_ready;
    } axi_req_t;

    typedef struct packed {
        logic   aw_ready;
        logic   ar_ready;
        logic   w_ready;
        logic   b_valid;
        axi_b_t b;
        logic   r_valid;
        axi_r_t r;
    } axi_resp_t;

endpackage
